//--- hdl/BusPkg.sv
package BusPkg;

    // ----------------------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------------------
    typedef logic [31:0] busAddrT;      // Byte address
    typedef logic [15:0] halfWordT;     // One beat
    typedef logic [3:0]  byteEnT;       // All zero means all four bytes
    typedef logic [1:0]  halfEnT;       // Byte enables within a beat

    // ----------------------------------------------------------------------
    // Access modes
    // ----------------------------------------------------------------------
    typedef logic [1:0]  accessModeT;

    localparam accessModeT ModeHalf  = 2'b01;   // Single half-word
    localparam accessModeT ModeWord  = 2'b10;   // Two beats, 4-byte aligned
    localparam accessModeT ModeBlock = 2'b11;   // Eight beats, 16-byte aligned

    localparam int BlockBeats = 8;

    // Sequencer FSM
    typedef enum logic [2:0] {
        SeqIdle,
        SeqAddrLo,
        SeqRead,
        SeqWrite,
        SeqDone
    } seqStateT;

endpackage

//--- hdl/MapPkg.sv
package MapPkg;

    // One-hot device select
    typedef logic [1:0] devSelT;

    localparam int DevRom = 0;
    localparam int DevRam = 1;

    // ----------------------------------------------------------------------
    // Address regions
    // ----------------------------------------------------------------------
    localparam logic [15:0] RomHiUncached  = 16'hbfc0;   // Matched on bits 31:16
    localparam logic [15:0] RomHiCached    = 16'h9fc0;
    localparam logic [11:0] RamTopUncached = 12'ha00;    // Matched on bits 31:20
    localparam logic [11:0] RamTopCached   = 12'h800;

    // Devices that take writes
    localparam devSelT CapWritable = 2'b10;

    // Block access is allowed on the cached aliases only

    // ----------------------------------------------------------------------
    // Target sizes
    // ----------------------------------------------------------------------
    typedef logic [4:0] romIndexT;      // Half-word index
    typedef logic [7:0] ramIndexT;      // Word index

    localparam int RomDepth = 32;
    localparam int RamDepth = 256;

endpackage

//--- hdl/BusAddrDecode.sv
`timescale 1ns/1ps

module BusAddrDecode (
    input  BusPkg::busAddrT    Address,
    input  BusPkg::accessModeT Mode,
    input  logic               Write,
    output MapPkg::devSelT     DevSel,
    output logic               Accept
);
    import BusPkg::*;
    import MapPkg::*;

    logic [15:0] addrHi;
    logic [11:0] addrTop;
    logic        cached;
    logic        writable;

    assign addrHi  = Address[31:16];
    assign addrTop = Address[31:20];

    // Both aliases of a target select the same device
    assign DevSel[DevRom] = (addrHi == RomHiUncached) || (addrHi == RomHiCached);
    assign DevSel[DevRam] = (addrTop == RamTopUncached) || (addrTop == RamTopCached);

    assign cached   = (addrHi == RomHiCached) || (addrTop == RamTopCached);
    assign writable = |(DevSel & CapWritable);

    // Hit, then direction, then block only on a cached alias
    assign Accept = (|DevSel)
                 && (!Write || writable)
                 && ((Mode != ModeBlock) || cached);

    // Regions must never overlap
    always_comb begin
        assert ($onehot0(DevSel))
            else $error("BusAddrDecode: address %h hits more than one device", Address);
    end

endmodule

//--- hdl/BusSequencer.sv
`timescale 1ns/1ps

module BusSequencer (
    input  logic               Clk,
    input  logic               Reset_,
    input  logic               Strobe,
    input  logic               Write,
    input  logic               Block,
    input  BusPkg::byteEnT     ByteEnable,
    input  BusPkg::halfWordT   OutDA,
    input  logic               Accept,
    output BusPkg::busAddrT    Address,
    output BusPkg::accessModeT Mode,
    output logic               BeatRead,
    output logic               BeatWrite,
    output BusPkg::halfEnT     HalfEn,
    output logic               Reject
);
    import BusPkg::*;

    localparam int CntW = $clog2(BlockBeats);

    seqStateT         state;
    seqStateT         nextState;
    busAddrT          addrQ;
    busAddrT          addrLo;
    accessModeT       modeQ;
    accessModeT       modeNew;
    byteEnT           be32;
    logic             isUpper;
    logic             isLower;
    logic [CntW-1:0]  beatCnt;
    logic [CntW-1:0]  lastCnt;
    logic             rejectQ;

    // ----------------------------------------------------------------------
    // Mode and address from the master
    // ----------------------------------------------------------------------
    assign be32    = (ByteEnable == 4'b0000) ? 4'b1111 : ByteEnable;
    assign isUpper = (be32[1:0] == 2'b00);     // Only offset 0 and 1
    assign isLower = (be32[3:2] == 2'b00);
    assign modeNew = Block ? ModeBlock
                   : (isUpper || isLower) ? ModeHalf
                   : ModeWord;

    always_comb begin
        addrLo = {addrQ[31:16], OutDA};
        if (modeNew == ModeBlock)
            addrLo[3:0] = 4'h0;
        else if (modeNew == ModeWord)
            addrLo[1:0] = 2'b00;
        else
            addrLo[1:0] = {isLower, 1'b0};     // Lower half sits at offset 2
    end

    // Decode sees the full address already in the low-half cycle
    assign Address = (state == SeqAddrLo) ? addrLo : addrQ;
    assign Mode    = (state == SeqAddrLo) ? modeNew : modeQ;
    assign HalfEn  = (Mode == ModeBlock) ? 2'b11
                   : Address[1] ? be32[1:0]
                   : be32[3:2];

    always_comb begin
        case (Mode)
            ModeHalf: lastCnt = '0;
            ModeWord: lastCnt = CntW'(1);
            default:  lastCnt = CntW'(BlockBeats - 1);
        endcase
    end

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            SeqIdle:
                if (Strobe)
                    nextState = SeqAddrLo;
            SeqAddrLo:
                if (!Accept)
                    nextState = SeqDone;
                else if (Write)
                    nextState = SeqWrite;
                else
                    nextState = SeqRead;
            SeqRead, SeqWrite:
                if (beatCnt == lastCnt)
                    nextState = SeqDone;
            SeqDone:
                if (!Strobe)
                    nextState = SeqIdle;   // Master has closed the transfer
            default:
                nextState = SeqIdle;
        endcase
    end

    always_ff @(posedge Clk or negedge Reset_) begin
        if (!Reset_) begin
            state   <= SeqIdle;
            addrQ   <= '0;
            modeQ   <= ModeHalf;
            beatCnt <= '0;
            rejectQ <= 1'b0;
        end else begin
            state   <= nextState;
            rejectQ <= (state == SeqAddrLo) && !Accept;
            case (state)
                SeqIdle:
                    if (Strobe)
                        addrQ[31:16] <= OutDA;
                SeqAddrLo: begin
                    addrQ   <= addrLo;
                    modeQ   <= modeNew;
                    beatCnt <= '0;
                end
                SeqRead, SeqWrite: begin
                    addrQ   <= addrQ + 32'd2;      // Next half-word
                    beatCnt <= beatCnt + 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign BeatRead  = (state == SeqRead);
    assign BeatWrite = (state == SeqWrite);
    assign Reject    = rejectQ;

    // A rejected transfer issues no beat at all
    RejectNoBeat: assert property (@(posedge Clk) disable iff (!Reset_)
        Reject |-> !(BeatRead || BeatWrite));
    ReadWriteExcl: assert property (@(posedge Clk) disable iff (!Reset_)
        !(BeatRead && BeatWrite));

endmodule

//--- hdl/BootRom16.sv
`timescale 1ns/1ps

module BootRom16 (
    input  logic              Clk,
    input  logic              Read,
    input  MapPkg::romIndexT  Index,
    output BusPkg::halfWordT  RdData
);
    import BusPkg::*;
    import MapPkg::*;

    // Boot code, upper half of each instruction first
    localparam halfWordT BootTable [RomDepth] = '{
        16'h3c08, 16'ha000, 16'h3508, 16'h0100, 16'h3c09, 16'hbfc0, 16'h3529, 16'h0040,
        16'h8d2a, 16'h0000, 16'had0a, 16'h0000, 16'h2529, 16'h0004, 16'h2508, 16'h0004,
        16'h1520, 16'hfffb, 16'h0000, 16'h0000, 16'h3c1d, 16'ha000, 16'h37bd, 16'h03f0,
        16'h0c00, 16'h0040, 16'h0000, 16'h0000, 16'h1000, 16'hffff, 16'h0000, 16'h0000
    };

    always_ff @(posedge Clk) begin
        if (Read)
            RdData <= BootTable[Index];
    end

endmodule

//--- hdl/LocalRam32.sv
`timescale 1ns/1ps

module LocalRam32 (
    input  logic              Clk,
    input  logic              Read,
    input  logic              WriteEn,
    input  MapPkg::ramIndexT  Index,
    input  logic              Upper,      // Half at offset 0
    input  BusPkg::halfEnT    HalfEn,
    input  BusPkg::halfWordT  WrData,
    output BusPkg::halfWordT  RdData
);
    import MapPkg::*;

    logic [31:0] mem [RamDepth];

    // ----------------------------------------------------------------------
    // Byte-enabled half-word write
    // ----------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (WriteEn) begin
            if (Upper) begin
                if (HalfEn[1])
                    mem[Index][31:24] <= WrData[15:8];
                if (HalfEn[0])
                    mem[Index][23:16] <= WrData[7:0];
            end else begin
                if (HalfEn[1])
                    mem[Index][15:8] <= WrData[15:8];
                if (HalfEn[0])
                    mem[Index][7:0] <= WrData[7:0];
            end
        end
    end

    // Registered half-word read
    always_ff @(posedge Clk) begin
        if (Read)
            RdData <= Upper ? mem[Index][31:16] : mem[Index][15:0];
    end

endmodule

//--- hdl/BusResponse.sv
`timescale 1ns/1ps

module BusResponse (
    input  logic              Clk,
    input  logic              Reset_,
    input  logic              BeatRead,
    input  logic              BeatWrite,
    input  logic              Reject,
    input  MapPkg::devSelT    DevSel,
    input  BusPkg::halfWordT  RomData,
    input  BusPkg::halfWordT  RamData,
    output logic              Ready,
    output logic              Error,
    output BusPkg::halfWordT  InD
);
    import MapPkg::*;

    logic   readQ;      // Read data arrives this cycle
    devSelT selQ;       // Its source

    always_ff @(posedge Clk or negedge Reset_) begin
        if (!Reset_) begin
            readQ <= 1'b0;
            selQ  <= '0;
        end else begin
            readQ <= BeatRead;
            selQ  <= DevSel;
        end
    end

    assign Ready = readQ || BeatWrite || Reject;
    assign Error = Reject;

    always_comb begin
        InD = '0;                                  // Zero outside read beats
        if (readQ && selQ[DevRam])
            InD = RamData;
        else if (readQ && selQ[DevRom])
            InD = RomData;
    end

    // Error comes with a single Ready that ends the transfer
    ErrorOneReady: assert property (@(posedge Clk) disable iff (!Reset_)
        Error |-> Ready ##1 !Ready);

endmodule

//--- hdl/BusController16.sv
`timescale 1ns/1ps

module BusController16 (
    input  logic              Clk,
    input  logic              Reset_,
    input  logic              Strobe,
    input  logic              Write,
    input  logic              Block,
    input  BusPkg::byteEnT    ByteEnable,
    input  BusPkg::halfWordT  OutDA,
    output logic              Ready,
    output logic              Error,
    output BusPkg::halfWordT  InD
);
    import BusPkg::*;
    import MapPkg::*;

    busAddrT    address;
    accessModeT mode;
    halfEnT     halfEn;
    logic       beatRead;
    logic       beatWrite;
    logic       reject;
    logic       accept;
    devSelT     devSel;
    halfWordT   romData;
    halfWordT   ramData;

    // ----------------------------------------------------------------------
    // Target fields and strobes
    // ----------------------------------------------------------------------
    romIndexT   romIndex;
    ramIndexT   ramIndex;
    logic       ramUpper;
    logic       romRead;
    logic       ramRead;
    logic       ramWrite;

    assign romIndex = address[5:1];
    assign ramIndex = address[9:2];
    assign ramUpper = ~address[1];                 // Offset 0 lives in bits 31:16
    assign romRead  = beatRead  & devSel[DevRom];
    assign ramRead  = beatRead  & devSel[DevRam];
    assign ramWrite = beatWrite & devSel[DevRam];

    BusSequencer BusSequencer_i (
        .Clk(Clk), .Reset_(Reset_), .Strobe(Strobe), .Write(Write), .Block(Block),
        .ByteEnable(ByteEnable), .OutDA(OutDA), .Accept(accept),
        .Address(address), .Mode(mode), .BeatRead(beatRead), .BeatWrite(beatWrite),
        .HalfEn(halfEn), .Reject(reject)
    );

    BusAddrDecode BusAddrDecode_i (
        .Address(address), .Mode(mode), .Write(Write), .DevSel(devSel), .Accept(accept)
    );

    BootRom16 BootRom16_i (
        .Clk(Clk), .Read(romRead), .Index(romIndex), .RdData(romData)
    );

    LocalRam32 LocalRam32_i (
        .Clk(Clk), .Read(ramRead), .WriteEn(ramWrite), .Index(ramIndex),
        .Upper(ramUpper), .HalfEn(halfEn), .WrData(OutDA), .RdData(ramData)
    );

    BusResponse BusResponse_i (
        .Clk(Clk), .Reset_(Reset_), .BeatRead(beatRead), .BeatWrite(beatWrite),
        .Reject(reject), .DevSel(devSel), .RomData(romData), .RamData(ramData),
        .Ready(Ready), .Error(Error), .InD(InD)
    );

endmodule

//--- verif/ClockGen.sv
`timescale 1ns/1ps

module ClockGen (
    output logic Clk,
    output logic Reset_
);

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;        // 20 ns period
    end

    // Reset held over four rising edges and released on a falling edge
    initial begin
        Reset_ = 1'b0;
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        Reset_ = 1'b1;
    end

endmodule

//--- verif/BusMonitor.sv
`timescale 1ns/1ps

module BusMonitor (
    input  logic                                      Clk,
    input  logic                                      Reset_,
    input  logic                                      Ready,
    input  logic                                      Error,
    input  BusPkg::halfWordT                          InD,
    input  logic                                      TestActive,
    input  int                                        TestNum,
    input  logic                                      IsRead,
    input  logic                                      ExpError,
    input  int                                        ExpCount,
    input  BusPkg::busAddrT                           TestAddr,
    input  BusPkg::halfWordT [BusPkg::BlockBeats-1:0] ExpBeats,
    input  logic                                      RunDone,
    output int                                        ErrorCount,
    output int                                        TestCount,
    output logic                                      Reported
);
    import BusPkg::*;

    int       cycle;         // Cycles since Strobe rose
    int       beatIdx;
    int       firstCycle;
    int       testErrors;
    int       failCount;
    logic     wasActive;
    halfWordT expData;

    initial begin
        ErrorCount = 0;
        TestCount  = 0;
        Reported   = 1'b0;
        failCount  = 0;
        testErrors = 0;
        wasActive  = 1'b0;
    end

    task flagMismatch(input string name, input int expVal, input int gotVal);
        ErrorCount++;
        testErrors++;
        $display("ERROR at %0d ns: %s expected %0h, got %0h", $time, name, expVal, gotVal);
    endtask

    task noteProblem(input string msg);
        ErrorCount++;
        testErrors++;
        $display("At %0d ns: %s", $time, msg);
    endtask

    // ----------------------------------------------------------------------
    // One Ready beat of the running transfer
    // ----------------------------------------------------------------------
    task checkBeat();
        firstCycle = (IsRead && !ExpError) ? 3 : 2;    // L+2 for reads, L+1 otherwise
        if (beatIdx >= ExpCount) begin
            noteProblem($sformatf("test %0d has more Ready beats than the %0d expected",
                                  TestNum, ExpCount));
        end else begin
            if (cycle != firstCycle + beatIdx)
                flagMismatch("Ready cycle", firstCycle + beatIdx, cycle);
            if (Error != ExpError)
                flagMismatch("Error", int'(ExpError), int'(Error));
            expData = (IsRead && !ExpError) ? ExpBeats[beatIdx] : '0;
            if (InD != expData)
                flagMismatch("InD", int'(expData), int'(InD));
        end
        beatIdx++;
    endtask

    task closeTest();
        if (beatIdx != ExpCount)
            noteProblem($sformatf("test %0d ended after %0d Ready beats, %0d were expected",
                                  TestNum, beatIdx, ExpCount));
        TestCount++;
        if (testErrors != 0)
            failCount++;
        $display("Test %0d: %s %h, %0d beat(s)%s, %s", TestNum, IsRead ? "read" : "write",
                 TestAddr, ExpCount, ExpError ? " rejected" : "",
                 (testErrors == 0) ? "pass" : "FAIL");
    endtask

    // Samples the cycle that ends at each rising edge
    always @(posedge Clk) begin
        if (Reset_) begin
            if (TestActive) begin
                if (!wasActive) begin
                    cycle      = 0;
                    beatIdx    = 0;
                    testErrors = 0;
                end else begin
                    cycle++;
                end
                if (Ready)
                    checkBeat();
            end else begin
                if (wasActive)
                    closeTest();
                if (Ready)
                    noteProblem("Ready went high outside any transfer");
            end
            if (!Ready && InD != '0)
                flagMismatch("InD", 0, int'(InD));
            if (RunDone && !Reported) begin
                $display("Tests run: %0d, failed: %0d, check errors: %0d",
                         TestCount, failCount, ErrorCount);
                Reported = 1'b1;
            end
            wasActive = TestActive;
        end
    end

endmodule

//--- verif/BusController16Tb.sv
`timescale 1ns/1ps

module BusController16Tb;
    import BusPkg::*;

    localparam int RecWords  = 14;     // dir blk be addr cnt d0..d7 err
    localparam int MaxTests  = 40;
    localparam int BeatLimit = 16;     // Cycles allowed for all Ready beats

    logic     Clk;
    logic     Reset_;
    logic     Strobe;
    logic     Write;
    logic     Block;
    byteEnT   ByteEnable;
    halfWordT OutDA;
    logic     Ready;
    logic     Error;
    halfWordT InD;

    logic                      testActive;
    logic                      isRead;
    logic                      expError;
    logic                      runDone;
    logic                      reported;
    logic                      tbFail;
    int                        testNum;
    int                        expCount;
    int                        errorCount;
    int                        testCount;
    int                        runCount;
    int                        seed;
    int                        gap;
    busAddrT                   testAddr;
    halfWordT [BlockBeats-1:0] expBeats;
    logic [31:0]               patterns [MaxTests * RecWords];

    ClockGen ClockGen_i (.Clk(Clk), .Reset_(Reset_));

    BusController16 BusController16_i (
        .Clk(Clk), .Reset_(Reset_), .Strobe(Strobe), .Write(Write), .Block(Block),
        .ByteEnable(ByteEnable), .OutDA(OutDA), .Ready(Ready), .Error(Error), .InD(InD)
    );

    BusMonitor BusMonitor_i (
        .Clk(Clk), .Reset_(Reset_), .Ready(Ready), .Error(Error), .InD(InD),
        .TestActive(testActive), .TestNum(testNum), .IsRead(isRead), .ExpError(expError),
        .ExpCount(expCount), .TestAddr(testAddr), .ExpBeats(expBeats), .RunDone(runDone),
        .ErrorCount(errorCount), .TestCount(testCount), .Reported(reported)
    );

    task automatic waitForReset();
        int waited;
        waited = 0;
        while (Reset_ !== 1'b1 && waited < 10) begin
            @(posedge Clk);
            waited++;
        end
        if (Reset_ !== 1'b1) begin
            $display("Timeout: reset was never released");
            tbFail = 1'b1;
        end
    endtask

    // ----------------------------------------------------------------------
    // One transfer, driven on falling edges
    // ----------------------------------------------------------------------
    task automatic runTransfer(input int n);
        int   base;
        int   beats;
        int   waited;
        logic isWrite;
        logic done;
        base    = n * RecWords;
        isWrite = patterns[base][0];
        @(negedge Clk);
        Strobe     = 1'b1;
        Write      = isWrite;
        Block      = patterns[base + 1][0];
        ByteEnable = patterns[base + 2][3:0];
        OutDA      = patterns[base + 3][31:16];          // High half first
        testNum    = n + 1;
        isRead     = !isWrite;
        testAddr   = patterns[base + 3];
        expCount   = patterns[base + 4];
        expError   = patterns[base + 13][0];
        for (int i = 0; i < BlockBeats; i++)
            expBeats[i] = patterns[base + 5 + i][15:0];
        testActive = 1'b1;
        @(negedge Clk);
        OutDA  = patterns[base + 3][15:0];
        beats  = 0;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < BeatLimit) begin
            @(negedge Clk);
            waited++;
            if (Ready) begin
                if (isWrite && beats < BlockBeats)
                    OutDA = expBeats[beats];             // Written in this Ready cycle
                beats++;
                if (Error || beats >= expCount)
                    done = 1'b1;
            end
        end
        if (!done) begin
            $display("Timeout: transfer %0d saw only %0d of %0d Ready beats",
                     n + 1, beats, expCount);
            tbFail = 1'b1;
        end
        @(negedge Clk);
        Strobe     = 1'b0;
        testActive = 1'b0;
        Write      = 1'b0;
        Block      = 1'b0;
        ByteEnable = '0;
        OutDA      = '0;
    endtask

    task automatic awaitSummary();
        int waited;
        waited = 0;
        while (!reported && waited < 10) begin
            @(negedge Clk);
            waited++;
        end
        if (!reported) begin
            $display("Timeout: the monitor never printed its summary");
            tbFail = 1'b1;
        end
    endtask

    initial begin
        Strobe     = 1'b0;
        Write      = 1'b0;
        Block      = 1'b0;
        ByteEnable = '0;
        OutDA      = '0;
        testActive = 1'b0;
        isRead     = 1'b0;
        expError   = 1'b0;
        runDone    = 1'b0;
        testNum    = 0;
        expCount   = 0;
        testAddr   = '0;
        expBeats   = '0;
        tbFail     = 1'b0;
        runCount   = 0;
        seed       = 6;
        $readmemh("verif/BusPatterns.txt", patterns);
        waitForReset();
        while (!tbFail && runCount < MaxTests && patterns[runCount * RecWords] <= 32'd1) begin
            runTransfer(runCount);
            runCount++;
            gap = $unsigned($random(seed)) % 4;          // Idle gap of 0 to 3 cycles
            repeat (gap) @(negedge Clk);
        end
        if (runCount == 0 && !tbFail) begin
            $display("No transfers were read from verif/BusPatterns.txt");
            tbFail = 1'b1;
        end else if (!tbFail && runCount < MaxTests
                     && patterns[runCount * RecWords] != 32'hf) begin
            $display("Patterns file has a bad direction field in transfer %0d", runCount + 1);
            tbFail = 1'b1;
        end
        @(negedge Clk);
        runDone = 1'b1;
        awaitSummary();
        if (!tbFail && errorCount == 0 && testCount == runCount)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- verif/BusPatterns.txt
// dir(0 rd,1 wr) block byteEn address beats d0 d1 d2 d3 d4 d5 d6 d7 error
// Reads list the expected beats, writes the data to drive, f ends the list
0 0 c bfc00000 1 3c08 0 0 0 0 0 0 0 0
0 0 3 9fc00002 1 a000 0 0 0 0 0 0 0 0
0 0 0 9fc00008 2 3c09 bfc0 0 0 0 0 0 0 0
0 0 f bfc00030 2 0c00 0040 0 0 0 0 0 0 0
1 0 f a0000010 2 1234 5678 0 0 0 0 0 0 0
0 0 0 80000010 2 1234 5678 0 0 0 0 0 0 0
1 0 f 80000020 2 cafe f00d 0 0 0 0 0 0 0
0 0 f a0000020 2 cafe f00d 0 0 0 0 0 0 0
1 0 2 a0000012 1 ab99 0 0 0 0 0 0 0 0
1 0 4 80000020 1 0011 0 0 0 0 0 0 0 0
1 1 0 80000047 8 1111 2222 3333 4444 5555 6666 7777 8888 0
0 1 0 8000004a 8 1111 2222 3333 4444 5555 6666 7777 8888 0
1 0 f bfc00000 1 dead beef 0 0 0 0 0 0 1
1 1 0 a0000040 1 9999 9999 9999 9999 9999 9999 9999 9999 1
0 1 0 bfc00010 1 0 0 0 0 0 0 0 0 1
1 0 f 10000010 1 ffff ffff 0 0 0 0 0 0 1
0 0 f 00000000 1 0 0 0 0 0 0 0 0 1
0 0 f a0000010 2 1234 ab78 0 0 0 0 0 0 0
0 0 0 80000020 2 ca11 f00d 0 0 0 0 0 0 0
0 1 0 80000040 8 1111 2222 3333 4444 5555 6666 7777 8888 0
0 0 f bfc00000 2 3c08 a000 0 0 0 0 0 0 0
f

//--- BusController16.f
hdl/BusPkg.sv
hdl/MapPkg.sv
hdl/BusAddrDecode.sv
hdl/BusSequencer.sv
hdl/BootRom16.sv
hdl/LocalRam32.sv
hdl/BusResponse.sv
hdl/BusController16.sv
verif/ClockGen.sv
verif/BusMonitor.sv
verif/BusController16Tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and pass only if the testbench reports no errors
cd "$(dirname "$0")" \
    && verilator --binary --assert -Wno-fatal -f BusController16.f \
        --top-module BusController16Tb -o simv \
    && { simOut="$(./obj_dir/simv 2>&1)" || true; } \
    && printf '%s\n' "$simOut" \
    && printf '%s\n' "$simOut" | grep -qx "No errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
